// ==== flist.f ====
+incdir+include
src/dcache_pkg.sv
src/dcache_arbiter.sv
src/dcache_array.sv
src/dcache_load_unit.sv
src/dcache_store_unit.sv
src/dcache_refill_unit.sv
src/dcache_top.sv
test/dcache_tb.sv

// ==== test/dcache_tb.sv ====
`include "dcache_consts.svh"

module dcache_tb;
    import dcache_pkg::*;

    // rough cycle budget of each test, in order
    localparam int TEST_CYCLES = 20 + 40 + 60 + 90 + 60 + 200;

    logic        clk = 1'b0;
    logic        rst;
    logic        load_valid, load_ready, load_resp_valid;
    load_req_t   load_req;
    load_resp_t  load_resp;
    logic        store_valid, store_ready, store_resp_valid;
    store_req_t  store_req;
    store_resp_t store_resp;
    logic        refill_valid, refill_ready;
    refill_t     refill_in;
    logic        miss_valid, miss_credit;
    miss_req_t   miss_req;

    // reference model state
    logic  m_valid [`DCACHE_WAYS][`DCACHE_SETS];
    tag_t  m_tag   [`DCACHE_WAYS][`DCACHE_SETS];
    line_t m_line  [`DCACHE_WAYS][`DCACHE_SETS];
    int    m_ptr   [`DCACHE_SETS];

    load_resp_t  load_exp[$];
    int          load_due[$];
    store_resp_t store_exp[$];
    int          store_due[$];
    miss_req_t   miss_exp[$];
    int          miss_due[$];

    int    cyc = 0;
    int    errors = 0;
    int    checks = 0;
    int    err_start;
    int    owed = 0;
    int    miss_seen = 0;
    bit    hold_credits = 1'b0;
    string cur_test = "reset";

    dcache_top dut (.*);

    always #4 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    function automatic set_idx_t set_of(addr_t a);
        return a[`DCACHE_LINE_OFF_W +: `DCACHE_SET_W];
    endfunction

    function automatic word_off_t word_of(addr_t a);
        return a[`DCACHE_BYTE_OFF_W +: `DCACHE_WORD_OFF_W];
    endfunction

    function automatic addr_t make_addr(tag_t t, set_idx_t s, word_off_t w);
        return {t, s, w, {`DCACHE_BYTE_OFF_W{1'b0}}};
    endfunction

    function automatic int find_way(addr_t a);
        int found;
        found = -1;
        for (int i = 0; i < `DCACHE_WAYS; i++) begin
            if (m_valid[i][set_of(a)] && m_tag[i][set_of(a)] == a[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W])
                found = i;
        end
        return found;
    endfunction

    function automatic load_resp_t ref_load(addr_t a);
        load_resp_t r;
        int w;
        w = find_way(a);
        r.hit = (w >= 0);
        r.data = '0;
        if (w >= 0)
            r.data = m_line[w][set_of(a)][word_of(a)];
        return r;
    endfunction

    // a hit merges the masked bytes into the model
    function automatic store_resp_t ref_store(store_req_t s);
        store_resp_t r;
        int w;
        word_t cur;
        w = find_way(s.addr);
        r.hit = (w >= 0);
        if (w >= 0) begin
            cur = m_line[w][set_of(s.addr)][word_of(s.addr)];
            for (int b = 0; b < `DCACHE_BYTES; b++) begin
                if (s.mask[b])
                    cur[8*b +: 8] = s.data[8*b +: 8];
            end
            m_line[w][set_of(s.addr)][word_of(s.addr)] = cur;
        end
        return r;
    endfunction

    task automatic model_refill(refill_t r);
        set_idx_t s;
        int way;
        s = set_of(r.line_addr);
        way = m_ptr[s];
        m_valid[way][s] = 1'b1;
        m_tag[way][s] = r.line_addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
        m_line[way][s] = r.data;
        m_ptr[s] = (way + 1) % `DCACHE_WAYS;
    endtask

    task automatic check_load(load_resp_t exp, load_resp_t act);
        checks++;
        if (act.hit !== exp.hit || (exp.hit && act.data !== exp.data)) begin
            errors++;
            $display("MISMATCH %s load: expected hit=%0b data=%h, actual hit=%0b data=%h",
                     cur_test, exp.hit, exp.data, act.hit, act.data);
        end
    endtask

    task automatic check_store(store_resp_t exp, store_resp_t act);
        checks++;
        if (act.hit !== exp.hit) begin
            errors++;
            $display("MISMATCH %s store: expected hit=%0b, actual hit=%0b",
                     cur_test, exp.hit, act.hit);
        end
    endtask

    task automatic check_miss(miss_req_t exp, miss_req_t act);
        checks++;
        if (act.line_addr !== exp.line_addr) begin
            errors++;
            $display("MISMATCH %s miss: expected line %h, actual line %h",
                     cur_test, exp.line_addr, act.line_addr);
        end
    endtask

    task automatic fail(string what);
        errors++;
        $display("ERROR %s: %s", cur_test, what);
    endtask

    // responses are due exactly two cycles after acceptance
    always @(negedge clk) begin
        if (load_due.size() > 0 && load_due[0] == cyc) begin
            if (load_resp_valid)
                check_load(load_exp[0], load_resp);
            else
                fail("load response missing two cycles after acceptance");
            void'(load_exp.pop_front());
            void'(load_due.pop_front());
        end else if (load_resp_valid) begin
            fail("load response with no load accepted");
        end
        if (store_due.size() > 0 && store_due[0] == cyc) begin
            if (store_resp_valid)
                check_store(store_exp[0], store_resp);
            else
                fail("store response missing two cycles after acceptance");
            void'(store_exp.pop_front());
            void'(store_due.pop_front());
        end else if (store_resp_valid) begin
            fail("store response with no store accepted");
        end
        // only one store may be in flight
        if (store_valid && store_ready) begin
            foreach (store_due[i]) begin
                if (store_due[i] == cyc + 1)
                    fail("store accepted while another store was in flight");
            end
        end
        if (miss_due.size() > 0 && miss_due[0] == cyc) begin
            if (miss_valid)
                check_miss(miss_exp[0], miss_req);
            else
                fail("miss request missing after a load miss");
            void'(miss_exp.pop_front());
            void'(miss_due.pop_front());
        end else if (miss_valid) begin
            fail("miss request with no load miss");
        end
        if (miss_valid) begin
            miss_seen++;
            if (!hold_credits)
                owed++;
        end
    end

    // next level hands back one credit per cycle
    always @(posedge clk) begin
        #1;
        miss_credit = (owed > 0);
        if (owed > 0)
            owed--;
    end

    initial begin
        repeat (10 + TEST_CYCLES * 4) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", TEST_CYCLES * 4);
        $display("Finished with errors");
        $finish;
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic load_op(addr_t a);
        load_resp_t exp;
        miss_req_t m;
        load_valid = 1'b1;
        load_req.addr = a;
        do @(negedge clk); while (!load_ready);
        exp = ref_load(a);
        load_exp.push_back(exp);
        load_due.push_back(cyc + 2);
        if (!exp.hit) begin
            m.line_addr = a & ~addr_t'((1 << `DCACHE_LINE_OFF_W) - 1);
            miss_exp.push_back(m);
            miss_due.push_back(cyc + 2);
        end
        next_cycle();
        load_valid = 1'b0;
    endtask

    task automatic store_op(addr_t a, word_t d, byte_mask_t m);
        store_valid = 1'b1;
        store_req.addr = a;
        store_req.data = d;
        store_req.mask = m;
        do @(negedge clk); while (!store_ready);
        store_exp.push_back(ref_store(store_req));
        store_due.push_back(cyc + 2);
        next_cycle();
        store_valid = 1'b0;
    endtask

    // waits until the buffered line has been written
    task automatic refill_op(addr_t line_addr);
        refill_valid = 1'b1;
        refill_in.line_addr = line_addr;
        for (int w = 0; w < `DCACHE_LINE_WORDS; w++)
            refill_in.data[w] = $urandom;
        do @(negedge clk); while (!refill_ready);
        model_refill(refill_in);
        next_cycle();
        refill_valid = 1'b0;
        do @(negedge clk); while (!refill_ready);
        next_cycle();
    endtask

    task automatic stall_check(int n);
        repeat (n) begin
            @(negedge clk);
            if (load_ready)
                fail("load accepted with no miss credit left");
        end
    endtask

    task automatic start_test(string name);
        cur_test = name;
        err_start = errors;
    endtask

    task automatic end_test();
        do @(negedge clk);
        while (load_due.size() || store_due.size() || miss_due.size() || owed > 0);
        $display("%s: %0d errors", cur_test, errors - err_start);
        next_cycle();
    endtask

    initial begin
        addr_t a;
        int    miss_base;
        void'($urandom(32'h9d43_371a));
        for (int s = 0; s < `DCACHE_SETS; s++) begin
            m_ptr[s] = 0;
            for (int i = 0; i < `DCACHE_WAYS; i++)
                m_valid[i][s] = 1'b0;
        end
        rst = 1'b0;
        load_valid = 1'b0;
        load_req = '0;
        store_valid = 1'b0;
        store_req = '0;
        refill_valid = 1'b0;
        refill_in = '0;
        miss_credit = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b1;
        @(negedge clk);
        if (load_resp_valid || store_resp_valid || miss_valid || !refill_ready)
            fail("outputs not in their reset state");
        next_cycle();

        start_test("cold miss");
        load_op(make_addr('h10, 4, 2));
        end_test();

        start_test("refill then hit");
        refill_op(make_addr('h10, 4, 0));
        for (int w = 0; w < `DCACHE_LINE_WORDS; w++)
            load_op(make_addr('h10, 4, w));
        end_test();

        start_test("store merge");
        store_op(make_addr('h10, 4, 1), 32'haabb_ccdd, 4'b0101);
        store_op(make_addr('h20, 4, 1), 32'h1234_5678, 4'b1111);
        for (int w = 0; w < `DCACHE_LINE_WORDS; w++)
            load_op(make_addr('h10, 4, w));
        end_test();

        start_test("credit backpressure");
        hold_credits = 1'b1;
        miss_base = miss_seen;
        a = make_addr('h40, 7, 0);
        for (int i = 0; i < `DCACHE_MISS_CREDITS; i++)
            load_op(a + 32'h100 * i);
        load_valid = 1'b1;
        load_req.addr = a + 32'h100 * `DCACHE_MISS_CREDITS;
        stall_check(16);
        if (miss_seen - miss_base != `DCACHE_MISS_CREDITS)
            fail($sformatf("%0d miss requests sent, expected %0d", miss_seen - miss_base,
                           `DCACHE_MISS_CREDITS));
        owed = owed + 1;
        load_op(a + 32'h100 * `DCACHE_MISS_CREDITS);
        load_valid = 1'b1;
        load_req.addr = a + 32'h100 * (`DCACHE_MISS_CREDITS + 1);
        stall_check(16);
        if (miss_seen - miss_base != `DCACHE_MISS_CREDITS + 1)
            fail("a single credit did not allow exactly one more miss");
        next_cycle();
        load_valid = 1'b0;
        @(negedge clk);
        hold_credits = 1'b0;
        owed = owed + `DCACHE_MISS_CREDITS;
        end_test();

        start_test("round robin replace");
        refill_op(make_addr('h31, 9, 0));
        refill_op(make_addr('h32, 9, 0));
        refill_op(make_addr('h33, 9, 0));
        load_op(make_addr('h31, 9, 0));
        load_op(make_addr('h32, 9, 3));
        load_op(make_addr('h33, 9, 1));
        end_test();

        start_test("random stream");
        refill_op(make_addr('h55, 2, 0));
        refill_op(make_addr('h66, 3, 0));
        repeat (40) begin
            case ($urandom_range(0, 3))
                0: a = make_addr('h10, 4, $urandom_range(0, 3));
                1: a = make_addr('h55, 2, $urandom_range(0, 3));
                2: a = make_addr('h66, 3, $urandom_range(0, 3));
                default: a = make_addr('h77, 5, $urandom_range(0, 3));
            endcase
            if ($urandom_range(0, 2) == 0)
                store_op(a, $urandom, byte_mask_t'($urandom));
            else
                load_op(a);
        end
        end_test();

        $display("6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// ==== src/dcache_top.sv ====
module dcache_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load_valid,
    output logic                    load_ready,
    input  dcache_pkg::load_req_t   load_req,
    output logic                    load_resp_valid,
    output dcache_pkg::load_resp_t  load_resp,
    input  logic                    store_valid,
    output logic                    store_ready,
    input  dcache_pkg::store_req_t  store_req,
    output logic                    store_resp_valid,
    output dcache_pkg::store_resp_t store_resp,
    input  logic                    refill_valid,
    output logic                    refill_ready,
    input  dcache_pkg::refill_t     refill_in,
    output logic                    miss_valid,
    output dcache_pkg::miss_req_t   miss_req,
    input  logic                    miss_credit
);
    import dcache_pkg::*;

    array_req_t load_arb_req, store_rd_req, store_wr_req, refill_arb_req, array_req;
    array_rd_t  rd;
    logic       load_gnt, store_rd_gnt, refill_gnt;

    dcache_arbiter u_arbiter (
        .clk, .rst,
        .store_wr_req, .refill_req(refill_arb_req), .store_rd_req, .load_req(load_arb_req),
        .array_req,
        .store_wr_gnt(), .refill_gnt, .store_rd_gnt, .load_gnt
    );

    dcache_array u_array (.clk, .rst, .req(array_req), .rd);

    dcache_load_unit u_load (
        .clk, .rst, .load_valid, .load_req, .load_ready, .load_resp_valid, .load_resp,
        .miss_valid, .miss_req, .miss_credit, .arb_req(load_arb_req), .arb_gnt(load_gnt), .rd
    );

    // store write grant is implied by priority
    dcache_store_unit u_store (
        .clk, .rst, .store_valid, .store_req, .store_ready, .store_resp_valid, .store_resp,
        .rd_req(store_rd_req), .wr_req(store_wr_req), .rd_gnt(store_rd_gnt), .rd
    );

    dcache_refill_unit u_refill (
        .clk, .rst, .refill_valid, .refill_in, .refill_ready,
        .arb_req(refill_arb_req), .arb_gnt(refill_gnt)
    );

endmodule

// ==== src/dcache_refill_unit.sv ====
`include "dcache_consts.svh"

module dcache_refill_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   refill_valid,
    input  dcache_pkg::refill_t    refill_in,
    output logic                   refill_ready,
    output dcache_pkg::array_req_t arb_req,
    input  logic                   arb_gnt
);
    import dcache_pkg::*;

    logic     buf_valid;
    refill_t  buf_q;
    set_idx_t buf_set;
    way_idx_t rr_ptr [`DCACHE_SETS];

    assign refill_ready = !buf_valid;
    assign buf_set      = buf_q.line_addr[`DCACHE_LINE_OFF_W +: `DCACHE_SET_W];

    // whole line goes to the victim way
    always_comb begin
        arb_req          = '0;
        arb_req.en       = buf_valid;
        arb_req.we       = 1'b1;
        arb_req.fill     = 1'b1;
        arb_req.set      = buf_set;
        arb_req.way      = rr_ptr[buf_set];
        arb_req.word_sel = '1;
        arb_req.mask     = '1;
        arb_req.wline    = buf_q.data;
        arb_req.tag      = buf_q.line_addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            buf_valid <= 1'b0;
            for (int s = 0; s < `DCACHE_SETS; s++) begin
                rr_ptr[s] <= '0;
            end
        end else if (refill_valid && refill_ready) begin
            buf_valid <= 1'b1;
        end else if (arb_gnt) begin
            buf_valid <= 1'b0;
            if (rr_ptr[buf_set] == way_idx_t'(`DCACHE_WAYS - 1)) begin
                rr_ptr[buf_set] <= '0;
            end else begin
                rr_ptr[buf_set] <= rr_ptr[buf_set] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (refill_valid && refill_ready) begin
            buf_q <= refill_in;
        end
    end

endmodule

// ==== src/dcache_store_unit.sv ====
`include "dcache_consts.svh"

module dcache_store_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    store_valid,
    input  dcache_pkg::store_req_t  store_req,
    output logic                    store_ready,
    output logic                    store_resp_valid,
    output dcache_pkg::store_resp_t store_resp,
    output dcache_pkg::array_req_t  rd_req,
    output dcache_pkg::array_req_t  wr_req,
    input  logic                    rd_gnt,
    input  dcache_pkg::array_rd_t   rd
);
    import dcache_pkg::*;

    logic       s1_valid;
    store_req_t s1_req;
    logic       hit;
    way_idx_t   hit_idx;
    word_off_t  s1_word;

    assign store_ready = rd_gnt;
    assign s1_word     = s1_req.addr[`DCACHE_BYTE_OFF_W +: `DCACHE_WORD_OFF_W];

    // lookup phase, held off while a store is pending
    always_comb begin
        rd_req     = '0;
        rd_req.en  = store_valid && !s1_valid;
        rd_req.set = store_req.addr[`DCACHE_LINE_OFF_W +: `DCACHE_SET_W];
    end

    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < `DCACHE_WAYS; i++) begin
            if (rd.valid[i] && rd.tag[i] == s1_req.addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W]) begin
                hit     = 1'b1;
                hit_idx = way_idx_t'(i);
            end
        end
    end

    // write phase, one word of the hitting way
    always_comb begin
        wr_req       = '0;
        wr_req.en    = s1_valid && hit;
        wr_req.we    = 1'b1;
        wr_req.set   = s1_req.addr[`DCACHE_LINE_OFF_W +: `DCACHE_SET_W];
        wr_req.way   = hit_idx;
        wr_req.mask  = s1_req.mask;
        wr_req.wline = {`DCACHE_LINE_WORDS{s1_req.data}};
        for (int w = 0; w < `DCACHE_LINE_WORDS; w++) begin
            wr_req.word_sel[w] = (s1_word == word_off_t'(w));
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            s1_valid         <= 1'b0;
            store_resp_valid <= 1'b0;
        end else begin
            s1_valid         <= store_valid && store_ready;
            store_resp_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (store_valid && store_ready) begin
            s1_req <= store_req;
        end
        store_resp.hit <= hit;
    end

endmodule

// ==== src/dcache_load_unit.sv ====
`include "dcache_consts.svh"

module dcache_load_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load_valid,
    input  dcache_pkg::load_req_t  load_req,
    output logic                   load_ready,
    output logic                   load_resp_valid,
    output dcache_pkg::load_resp_t load_resp,
    output logic                   miss_valid,
    output dcache_pkg::miss_req_t  miss_req,
    input  logic                   miss_credit,
    output dcache_pkg::array_req_t arb_req,
    input  logic                   arb_gnt,
    input  dcache_pkg::array_rd_t  rd
);
    import dcache_pkg::*;

    logic        s1_valid;
    addr_t       s1_addr;
    logic [`DCACHE_WAYS-1:0] hit_way;
    logic        hit;
    word_t       hit_data;
    logic        miss_take;
    logic        credit_ok;
    credit_cnt_t credit_cnt;

    // loads still in stage 1 hold a credit until they resolve
    assign credit_ok  = credit_cnt > credit_cnt_t'(s1_valid);
    assign load_ready = arb_gnt;

    always_comb begin
        arb_req     = '0;
        arb_req.en  = load_valid && credit_ok;
        arb_req.set = load_req.addr[`DCACHE_LINE_OFF_W +: `DCACHE_SET_W];
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= load_valid && load_ready;
        end
    end

    always_ff @(posedge clk) begin
        s1_addr <= load_req.addr;
    end

    // tag compare and word select
    always_comb begin
        hit_data = '0;
        for (int i = 0; i < `DCACHE_WAYS; i++) begin
            hit_way[i] = rd.valid[i] && (rd.tag[i] == s1_addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W]);
            if (hit_way[i]) begin
                hit_data = rd.line[i][s1_addr[`DCACHE_BYTE_OFF_W +: `DCACHE_WORD_OFF_W]];
            end
        end
    end

    assign hit       = |hit_way;
    assign miss_take = s1_valid && !hit;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            load_resp_valid <= 1'b0;
            miss_valid      <= 1'b0;
            credit_cnt      <= credit_cnt_t'(`DCACHE_MISS_CREDITS);
        end else begin
            load_resp_valid <= s1_valid;
            miss_valid      <= miss_take;
            case ({miss_take, miss_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        load_resp.hit      <= hit;
        load_resp.data     <= hit_data;
        miss_req.line_addr <= {s1_addr[`DCACHE_ADDR_W-1:`DCACHE_LINE_OFF_W],
                               {`DCACHE_LINE_OFF_W{1'b0}}};
    end

    assert property (@(posedge clk) disable iff (!rst)
        miss_valid |-> $past(credit_cnt) != '0);

    assert property (@(posedge clk) disable iff (!rst)
        credit_cnt <= credit_cnt_t'(`DCACHE_MISS_CREDITS));

endmodule

// ==== src/dcache_array.sv ====
`include "dcache_consts.svh"

module dcache_array (
    input  logic                   clk,
    input  logic                   rst,
    input  dcache_pkg::array_req_t req,
    output dcache_pkg::array_rd_t  rd
);
    import dcache_pkg::*;

    tag_t  tag_mem  [`DCACHE_WAYS][`DCACHE_SETS];
    line_t data_mem [`DCACHE_WAYS][`DCACHE_SETS];
    logic [`DCACHE_WAYS-1:0][`DCACHE_SETS-1:0] valid_q;

    logic wr_en;
    logic rd_en;

    assign wr_en = req.en && req.we;
    assign rd_en = req.en && !req.we;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= '0;
        end else if (wr_en && req.fill) begin
            valid_q[req.way][req.set] <= 1'b1;
        end
    end

    // byte granular write into the selected words
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int w = 0; w < `DCACHE_LINE_WORDS; w++) begin
                for (int b = 0; b < `DCACHE_BYTES; b++) begin
                    if (req.word_sel[w] && req.mask[b]) begin
                        data_mem[req.way][req.set][w][8*b +: 8] <= req.wline[w][8*b +: 8];
                    end
                end
            end
            if (req.fill) begin
                tag_mem[req.way][req.set] <= req.tag;
            end
        end
    end

    // read all ways of the set, data out next cycle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int i = 0; i < `DCACHE_WAYS; i++) begin
                rd.valid[i] <= valid_q[i][req.set];
                rd.tag[i]   <= tag_mem[i][req.set];
                rd.line[i]  <= data_mem[i][req.set];
            end
        end
    end

    // a write must name a real way and touch at least one word
    assert property (@(posedge clk) disable iff (!rst)
        wr_en |-> (req.way < `DCACHE_WAYS) && (req.word_sel != '0));

endmodule

// ==== src/dcache_arbiter.sv ====
module dcache_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  dcache_pkg::array_req_t store_wr_req,
    input  dcache_pkg::array_req_t refill_req,
    input  dcache_pkg::array_req_t store_rd_req,
    input  dcache_pkg::array_req_t load_req,
    output dcache_pkg::array_req_t array_req,
    output logic                   store_wr_gnt,
    output logic                   refill_gnt,
    output logic                   store_rd_gnt,
    output logic                   load_gnt
);
    import dcache_pkg::*;

    client_e winner;

    // fixed priority, store write first
    always_comb begin
        winner = cl_none;
        if (store_wr_req.en) begin
            winner = cl_store_wr;
        end else if (refill_req.en) begin
            winner = cl_refill;
        end else if (store_rd_req.en) begin
            winner = cl_store_rd;
        end else if (load_req.en) begin
            winner = cl_load;
        end
    end

    always_comb begin
        unique case (winner)
            cl_store_wr: array_req = store_wr_req;
            cl_refill:   array_req = refill_req;
            cl_store_rd: array_req = store_rd_req;
            cl_load:     array_req = load_req;
            default:     array_req = '0;
        endcase
    end

    assign store_wr_gnt = (winner == cl_store_wr);
    assign refill_gnt   = (winner == cl_refill);
    assign store_rd_gnt = (winner == cl_store_rd);
    assign load_gnt     = (winner == cl_load);

    // a store write only follows its granted lookup
    assert property (@(posedge clk) disable iff (!rst)
        store_wr_req.en |-> $past(store_rd_gnt));

endmodule

// ==== src/dcache_pkg.sv ====
`include "dcache_consts.svh"

package dcache_pkg;

    typedef logic [`DCACHE_ADDR_W-1:0]     addr_t;
    typedef logic [`DCACHE_TAG_W-1:0]      tag_t;
    typedef logic [`DCACHE_SET_W-1:0]      set_idx_t;
    typedef logic [`DCACHE_WORD_OFF_W-1:0] word_off_t;
    typedef logic [`DCACHE_WAY_W-1:0]      way_idx_t;
    typedef logic [`DCACHE_WORD_W-1:0]     word_t;
    typedef logic [`DCACHE_BYTES-1:0]      byte_mask_t;
    typedef word_t [`DCACHE_LINE_WORDS-1:0] line_t;
    typedef logic [`DCACHE_CREDIT_W-1:0]   credit_cnt_t;

    typedef struct packed { addr_t addr; } load_req_t;
    typedef struct packed { logic hit; word_t data; } load_resp_t;
    typedef struct packed { addr_t addr; word_t data; byte_mask_t mask; } store_req_t;
    typedef struct packed { logic hit; } store_resp_t;
    typedef struct packed { addr_t line_addr; } miss_req_t;
    typedef struct packed { addr_t line_addr; line_t data; } refill_t;

    // fill marks a refill write, which also loads tag and sets valid
    typedef struct packed {
        logic                         en;
        set_idx_t                     set;
        logic                         we;
        way_idx_t                     way;
        logic [`DCACHE_LINE_WORDS-1:0] word_sel;
        byte_mask_t                   mask;
        line_t                        wline;
        logic                         fill;
        tag_t                         tag;
    } array_req_t;

    typedef struct packed {
        logic [`DCACHE_WAYS-1:0] valid;
        tag_t [`DCACHE_WAYS-1:0]  tag;
        line_t [`DCACHE_WAYS-1:0] line;
    } array_rd_t;

    typedef enum logic [2:0] {
        cl_none,
        cl_store_wr,
        cl_refill,
        cl_store_rd,
        cl_load
    } client_e;

endpackage

// ==== include/dcache_consts.svh ====
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// cache geometry
`define DCACHE_WAYS         2
`define DCACHE_SETS         16
`define DCACHE_LINE_WORDS   4

// address and data
`define DCACHE_ADDR_W       32
`define DCACHE_WORD_W       32

// credits handed out by the next level after reset
`define DCACHE_MISS_CREDITS 2

// derived widths
`define DCACHE_WAY_W        ($clog2(`DCACHE_WAYS))
`define DCACHE_SET_W        ($clog2(`DCACHE_SETS))
`define DCACHE_WORD_OFF_W   ($clog2(`DCACHE_LINE_WORDS))
`define DCACHE_BYTES        (`DCACHE_WORD_W / 8)
`define DCACHE_BYTE_OFF_W   ($clog2(`DCACHE_BYTES))
`define DCACHE_LINE_OFF_W   (`DCACHE_WORD_OFF_W + `DCACHE_BYTE_OFF_W)
`define DCACHE_TAG_W        (`DCACHE_ADDR_W - `DCACHE_SET_W - `DCACHE_LINE_OFF_W)
`define DCACHE_CREDIT_W     ($clog2(`DCACHE_MISS_CREDITS + 1))

`endif
